// File: rtl/z80_pkg.sv
`default_nettype none

package z80_pkg;

	////////////////////////////////////////////////////////////
	// bus widths
	////////////////////////////////////////////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] z80_addr_t;
	typedef logic [DATA_W-1:0] z80_data_t;

	////////////////////////////////////////////////////////////
	// synchronized bus
	////////////////////////////////////////////////////////////

	// active-high levels after the synchronizer
	typedef struct packed {
		logic iorq;
		logic mreq;
		logic rd;
		logic wr;
		logic m1;
	} z80_bus_t;

	// single-cycle strobes and the intack level
	typedef struct packed {
		logic iowr_s;
		logic iord_s;
		logic intack_s;
		logic intack;
	} z80_strb_t;

endpackage

`default_nettype wire

// File: rtl/conf_pkg.sv
`default_nettype none

package conf_pkg;

	////////////////////////////////////////////////////////////
	// port map
	////////////////////////////////////////////////////////////

	typedef logic [15:0] port_addr_t;

	localparam port_addr_t PORT_BORDER  = 16'h0FAF;
	localparam port_addr_t PORT_SYSCONF = 16'h20AF;
	localparam port_addr_t PORT_MEMCONF = 16'h21AF;
	localparam port_addr_t PORT_IM2VECT = 16'h24AF;

	// classic ula port decoded on the low byte only
	localparam logic [7:0] PORT_FE_LOW = 8'hFE;

	////////////////////////////////////////////////////////////
	// configuration registers
	////////////////////////////////////////////////////////////

	typedef logic [7:0] border_t;
	typedef logic [1:0] turbo_t;
	typedef logic [4:0] rompg_t;

	typedef struct packed {
		border_t    border;
		logic [7:0] sysconf;
		logic [7:0] memconf;
		logic [7:0] im2vect;
		logic       beep;
	} conf_regs_t;

	localparam conf_regs_t CONF_RESET = '{
		border:  8'h00,
		sysconf: 8'h00,
		memconf: 8'h00,
		im2vect: 8'hFF,
		beep:    1'b0
	};

	// writing a one here restarts the whole core
	localparam int SYSCONF_SOFTRST_BIT = 7;

endpackage

`default_nettype wire

// File: rtl/zsignals.sv
`timescale 1ns/100ps
`default_nettype none

module zsignals (
	input  logic               fclk,
	input  logic               rst_n,

	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,

	output z80_pkg::z80_bus_t  bus,
	output z80_pkg::z80_strb_t strb
);

	z80_pkg::z80_bus_t sync1;
	z80_pkg::z80_bus_t sync2;

	logic iowr;
	logic iord;
	logic intack;

	logic iowr_r;
	logic iord_r;
	logic intack_r;

	logic iowr_s;
	logic iord_s;
	logic intack_s;

	// two flops with inversion to active high on the way in
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			sync1 <= '{iorq: ~iorq_n, mreq: ~mreq_n, rd: ~rd_n, wr: ~wr_n, m1: ~m1_n};
			sync2 <= sync1;
		end
	end

	assign iowr   = sync2.iorq & sync2.wr & ~sync2.m1;
	assign iord   = sync2.iorq & sync2.rd & ~sync2.m1;
	assign intack = sync2.iorq & sync2.m1;

	// previous sample and registered rising edges
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			iowr_r   <= 1'b0;
			iord_r   <= 1'b0;
			intack_r <= 1'b0;
			iowr_s   <= 1'b0;
			iord_s   <= 1'b0;
			intack_s <= 1'b0;
		end else begin
			iowr_r   <= iowr;
			iord_r   <= iord;
			intack_r <= intack;
			iowr_s   <= iowr & ~iowr_r;
			iord_s   <= iord & ~iord_r;
			intack_s <= intack & ~intack_r;
		end
	end

	assign bus  = sync2;
	assign strb = '{iowr_s: iowr_s, iord_s: iord_s, intack_s: intack_s, intack: intack};

endmodule

`default_nettype wire

// File: rtl/resetter.sv
`timescale 1ns/100ps
`default_nettype none

module resetter #(
	parameter int RST_CNT_SIZE = 6
) (
	input  logic fclk,
	input  logic arst_n,
	input  logic soft_rst_req,
	output logic rst_n
);

	typedef logic [RST_CNT_SIZE-1:0] rst_cnt_t;

	rst_cnt_t cnt;
	logic     cnt_full;

	assign cnt_full = &cnt;

	// restart on either source and release once the counter saturates
	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			cnt   <= '0;
			rst_n <= 1'b0;
		end else if (soft_rst_req) begin
			cnt   <= '0;
			rst_n <= 1'b0;
		end else begin
			if (!cnt_full)
				cnt <= cnt + 1'b1;
			rst_n <= cnt_full;
		end
	end

endmodule

`default_nettype wire

// File: rtl/zports.sv
`timescale 1ns/100ps
`default_nettype none

module zports (
	input  logic                 fclk,
	input  logic                 rst_n,

	input  z80_pkg::z80_addr_t   a,
	input  z80_pkg::z80_data_t   zd_in,
	input  z80_pkg::z80_bus_t    bus,
	input  z80_pkg::z80_strb_t   strb,

	output conf_pkg::conf_regs_t regs,
	output logic                 soft_rst_req,

	output z80_pkg::z80_data_t   zd_out,
	output logic                 zd_oe
);

	// fe port layout
	localparam int FE_BORDER_W = 3;
	localparam int FE_BEEP_BIT = 4;

	localparam logic [7:0] SOFTRST_MASK = 8'(1) << conf_pkg::SYSCONF_SOFTRST_BIT;

	conf_pkg::conf_regs_t regs_q;

	logic io_rd;
	logic rd_hit;

	////////////////////////////////////////////////////////////
	// port writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			regs_q       <= conf_pkg::CONF_RESET;
			soft_rst_req <= 1'b0;
		end else begin
			soft_rst_req <= 1'b0;

			if (strb.iowr_s) begin
				if (a[7:0] == conf_pkg::PORT_FE_LOW) begin
					// upper border bits untouched
					regs_q.border[FE_BORDER_W-1:0] <= zd_in[FE_BORDER_W-1:0];
					regs_q.beep                    <= zd_in[FE_BEEP_BIT];
				end else begin
					case (a)
						conf_pkg::PORT_BORDER:
							regs_q.border <= zd_in;
						conf_pkg::PORT_SYSCONF: begin
							// reset request bit is not stored
							regs_q.sysconf <= zd_in & ~SOFTRST_MASK;
							soft_rst_req   <= zd_in[conf_pkg::SYSCONF_SOFTRST_BIT];
						end
						conf_pkg::PORT_MEMCONF:
							regs_q.memconf <= zd_in;
						conf_pkg::PORT_IM2VECT:
							regs_q.im2vect <= zd_in;
						default: ;
					endcase
				end
			end
		end
	end

	assign regs = regs_q;

	////////////////////////////////////////////////////////////
	// read and acknowledge mux
	////////////////////////////////////////////////////////////

	assign io_rd = bus.iorq & bus.rd & ~bus.m1;

	always_comb begin
		rd_hit = 1'b1;
		case (a)
			conf_pkg::PORT_BORDER:  zd_out = regs_q.border;
			conf_pkg::PORT_SYSCONF: zd_out = regs_q.sysconf;
			conf_pkg::PORT_MEMCONF: zd_out = regs_q.memconf;
			conf_pkg::PORT_IM2VECT: zd_out = regs_q.im2vect;
			default: begin
				zd_out = '0;
				rd_hit = 1'b0;
			end
		endcase

		// vector wins during acknowledge
		if (strb.intack)
			zd_out = regs_q.im2vect;
	end

	assign zd_oe = strb.intack | (io_rd & rd_hit);

endmodule

`default_nettype wire

// File: rtl/zint.sv
`timescale 1ns/100ps
`default_nettype none

module zint #(
	parameter int FRAME_LEN = 71680,
	parameter int INT_LEN   = 32
) (
	input  logic               fclk,
	input  logic               rst_n,
	input  z80_pkg::z80_strb_t strb,
	output logic               int_n
);

	localparam int FRAME_W = $clog2(FRAME_LEN + 1);
	localparam int LEN_W   = $clog2(INT_LEN + 1);

	typedef logic [FRAME_W-1:0] frame_cnt_t;
	typedef logic [LEN_W-1:0]   len_cnt_t;

	typedef enum logic {
		INT_IDLE,
		INT_ACTIVE
	} int_state_t;

	frame_cnt_t frame_cnt;
	len_cnt_t   len_cnt;
	int_state_t int_st;
	logic       frame_wrap;

	// free-running frame counter
	assign frame_wrap = (frame_cnt == frame_cnt_t'(FRAME_LEN - 1));

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (frame_wrap)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	// pulse ends on length or on acknowledge
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			int_st  <= INT_IDLE;
			len_cnt <= '0;
		end else if (frame_wrap) begin
			int_st  <= INT_ACTIVE;
			len_cnt <= '0;
		end else if (int_st == INT_ACTIVE) begin
			if (strb.intack_s || len_cnt == len_cnt_t'(INT_LEN - 1))
				int_st <= INT_IDLE;
			else
				len_cnt <= len_cnt + 1'b1;
		end
	end

	assign int_n = (int_st != INT_ACTIVE);

endmodule

`default_nettype wire

// File: rtl/zcore.sv
`timescale 1ns/100ps
`default_nettype none

module zcore #(
	parameter int RST_CNT_SIZE = 6,
	parameter int FRAME_LEN    = 71680,
	parameter int INT_LEN      = 32
) (
	input  logic               fclk,
	input  logic               arst_n,

	// z80 bus
	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,
	input  z80_pkg::z80_addr_t a,
	input  z80_pkg::z80_data_t zd_in,
	output z80_pkg::z80_data_t zd_out,
	output logic               zd_oe,
	output logic               int_n,
	output logic               res,

	// configuration
	output conf_pkg::border_t  border,
	output conf_pkg::turbo_t   turbo,
	output conf_pkg::rompg_t   rompg,
	output logic               beep
);

	logic                 rst_n;
	logic                 soft_rst_req;
	z80_pkg::z80_bus_t    bus;
	z80_pkg::z80_strb_t   strb;
	conf_pkg::conf_regs_t regs;

	resetter #(.RST_CNT_SIZE(RST_CNT_SIZE)) i_resetter (
		.fclk         (fclk),
		.arst_n       (arst_n),
		.soft_rst_req (soft_rst_req),
		.rst_n        (rst_n)
	);

	zsignals i_zsignals (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.bus    (bus),
		.strb   (strb)
	);

	zports i_zports (
		.fclk         (fclk),
		.rst_n        (rst_n),
		.a            (a),
		.zd_in        (zd_in),
		.bus          (bus),
		.strb         (strb),
		.regs         (regs),
		.soft_rst_req (soft_rst_req),
		.zd_out       (zd_out),
		.zd_oe        (zd_oe)
	);

	zint #(.FRAME_LEN(FRAME_LEN), .INT_LEN(INT_LEN)) i_zint (
		.fclk  (fclk),
		.rst_n (rst_n),
		.strb  (strb),
		.int_n (int_n)
	);

	assign res    = ~rst_n;
	assign border = regs.border;
	assign turbo  = regs.sysconf[$bits(conf_pkg::turbo_t)-1:0];
	assign rompg  = regs.memconf[$bits(conf_pkg::rompg_t)-1:0];
	assign beep   = regs.beep;

endmodule

`default_nettype wire

// File: verif/zcore_assert.sv
`timescale 1ns/100ps
`default_nettype none

module zcore_assert #(
	parameter int INT_LEN = 32
) (
	input logic               fclk,
	input logic               rst_n,
	input z80_pkg::z80_bus_t  bus,
	input z80_pkg::z80_strb_t strb,
	input logic               int_n
);

	int low_cnt;

	// length of the current int_n pulse
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n)
			low_cnt <= 0;
		else if (!int_n)
			low_cnt <= low_cnt + 1;
		else
			low_cnt <= 0;
	end

	iowr_single: assert property (@(posedge fclk) disable iff (!rst_n)
		strb.iowr_s |=> !strb.iowr_s)
		else $error("iowr_s high for more than one cycle");

	int_len_max: assert property (@(posedge fclk) disable iff (!rst_n)
		low_cnt <= INT_LEN)
		else $error("int_n low longer than %0d cycles", INT_LEN);

	// zd_oe is built from these, so they must be quiet
	oe_in_reset: assert property (@(posedge fclk)
		!rst_n |-> !strb.intack && !(bus.iorq && bus.rd))
		else $error("data bus drive requested during reset");

endmodule

bind zsignals zcore_assert i_sig_assert (
	.fclk  (fclk),
	.rst_n (rst_n),
	.bus   (bus),
	.strb  (strb),
	.int_n (1'b1)
);

bind zint zcore_assert #(.INT_LEN(INT_LEN)) i_int_assert (
	.fclk  (fclk),
	.rst_n (rst_n),
	.bus   ('0),
	.strb  (strb),
	.int_n (int_n)
);

`default_nettype wire

// File: verif/tb_zcore.sv
`timescale 1ns/100ps
`default_nettype none

module tb_zcore;

	localparam int RST_CNT_SIZE = 4;
	localparam int FRAME_LEN    = 400;
	localparam int INT_LEN      = 16;
	localparam int HOLD         = 8;

	// operation codes of the test file
	localparam logic [3:0] OP_WRITE = 4'h1;
	localparam logic [3:0] OP_READ  = 4'h2;
	localparam logic [3:0] OP_NODRV = 4'h3;
	localparam logic [3:0] OP_ACK   = 4'h4;
	localparam logic [3:0] OP_INT   = 4'h5;
	localparam logic [3:0] OP_SRST  = 4'h6;

	typedef struct packed {
		logic [3:0]         op;
		z80_pkg::z80_addr_t addr;
		z80_pkg::z80_data_t data;
		conf_pkg::border_t  border;
		conf_pkg::turbo_t   turbo;
		conf_pkg::rompg_t   rompg;
		logic               beep;
		z80_pkg::z80_data_t rd_val;
	} test_t;

	logic               fclk;
	logic               arst_n;
	logic               iorq_n;
	logic               mreq_n;
	logic               rd_n;
	logic               wr_n;
	logic               m1_n;
	z80_pkg::z80_addr_t a;
	z80_pkg::z80_data_t zd_in;
	z80_pkg::z80_data_t zd_out;
	logic               zd_oe;
	logic               int_n;
	logic               res;
	conf_pkg::border_t  border;
	conf_pkg::turbo_t   turbo;
	conf_pkg::rompg_t   rompg;
	logic               beep;

	int   cycle_cnt      = 0;
	int   timeout_cycles = 0;
	int   prev_fall      = -1;
	int   last_fall      = -1;
	logic int_n_d        = 1'b1;

	zcore #(
		.RST_CNT_SIZE (RST_CNT_SIZE),
		.FRAME_LEN    (FRAME_LEN),
		.INT_LEN      (INT_LEN)
	) i_zcore (
		.fclk   (fclk),
		.arst_n (arst_n),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.zd_in  (zd_in),
		.zd_out (zd_out),
		.zd_oe  (zd_oe),
		.int_n  (int_n),
		.res    (res),
		.border (border),
		.turbo  (turbo),
		.rompg  (rompg),
		.beep   (beep)
	);

	initial begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	// interrupt fall times and run limit
	always @(negedge fclk) begin
		cycle_cnt++;
		if (res) begin
			prev_fall = -1;
			last_fall = -1;
		end else if (int_n_d && !int_n) begin
			prev_fall = last_fall;
			last_fall = cycle_cnt;
		end
		int_n_d = int_n;
		if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
			$display("timeout: tests still running after %0d cycles", cycle_cnt);
			$display("Test failed");
			$fatal(1, "run stopped on timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_data(input string name, input z80_pkg::z80_data_t got,
		input z80_pkg::z80_data_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_border(input string name, input conf_pkg::border_t got,
		input conf_pkg::border_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_turbo(input string name, input conf_pkg::turbo_t got,
		input conf_pkg::turbo_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_rompg(input string name, input conf_pkg::rompg_t got,
		input conf_pkg::rompg_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////////////////////////

	task automatic io_write(input z80_pkg::z80_addr_t addr, input z80_pkg::z80_data_t data);
		@(posedge fclk);
		a      <= addr;
		zd_in  <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		repeat (HOLD) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic io_read(input z80_pkg::z80_addr_t addr, output logic oe,
		output z80_pkg::z80_data_t data);
		@(posedge fclk);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		repeat (HOLD - 1) @(posedge fclk);
		@(negedge fclk);
		oe   = zd_oe;
		data = zd_out;
		@(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic int_ack(output logic oe, output z80_pkg::z80_data_t data);
		@(posedge fclk);
		m1_n   <= 1'b0;
		iorq_n <= 1'b0;
		repeat (HOLD - 1) @(posedge fclk);
		@(negedge fclk);
		oe   = zd_oe;
		data = zd_out;
		@(posedge fclk);
		m1_n   <= 1'b1;
		iorq_n <= 1'b1;
	endtask

	task automatic idle_gap();
		int n;
		n = 4 + int'($urandom % 4);
		repeat (n) @(posedge fclk);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		test_t              tests[$];
		test_t              t;
		int                 fd;
		int                 n;
		int                 n_low;
		string              line;
		logic [3:0]         op_f;
		z80_pkg::z80_addr_t addr_f;
		z80_pkg::z80_data_t data_f;
		conf_pkg::border_t  border_f;
		conf_pkg::turbo_t   turbo_f;
		conf_pkg::rompg_t   rompg_f;
		logic               beep_f;
		z80_pkg::z80_data_t rd_f;
		logic               oe;
		z80_pkg::z80_data_t rd;

		void'($urandom(36932));
		arst_n = 1'b0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		a      = '0;
		zd_in  = '0;

		fd = $fopen("verif/zcore_tests.txt", "r");
		if (fd == 0)
			fail_run("cannot open the test file verif/zcore_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h", op_f, addr_f, data_f,
				border_f, turbo_f, rompg_f, beep_f, rd_f);
			if (n != 8)
				fail_run($sformatf("malformed test line: %s", line));
			t = '{op_f, addr_f, data_f, border_f, turbo_f, rompg_f, beep_f, rd_f};
			tests.push_back(t);
		end
		$fclose(fd);
		timeout_cycles = tests.size() * 20 + 2 * FRAME_LEN + 200;

		repeat (10) @(posedge fclk);
		arst_n <= 1'b1;
		while (res)
			@(negedge fclk);
		check_border("border", border, 8'h00);
		check_turbo("turbo", turbo, 2'd0);
		check_rompg("rompg", rompg, 5'd0);
		check_bit("beep", beep, 1'b0);
		check_bit("int_n", int_n, 1'b1);
		check_bit("zd_oe", zd_oe, 1'b0);

		foreach (tests[i]) begin
			t = tests[i];
			case (t.op)
				OP_WRITE:
					io_write(t.addr, t.data);
				OP_READ, OP_NODRV: begin
					io_read(t.addr, oe, rd);
					check_bit("zd_oe", oe, t.op == OP_READ);
					if (t.op == OP_READ)
						check_data("zd_out", rd, t.rd_val);
				end
				OP_ACK: begin
					while (int_n)
						@(negedge fclk);
					int_ack(oe, rd);
					check_bit("zd_oe", oe, 1'b1);
					check_data("zd_out", rd, t.rd_val);
					// released well before the full pulse length
					@(negedge fclk);
					check_bit("int_n", int_n, 1'b1);
				end
				OP_INT: begin
					while (!int_n)
						@(negedge fclk);
					while (int_n)
						@(negedge fclk);
					n_low = 0;
					while (!int_n) begin
						n_low++;
						@(negedge fclk);
					end
					check_cycles("int_n low cycles", n_low, INT_LEN);
					if (prev_fall < 0)
						fail_run("fewer than two interrupts seen since reset");
					check_cycles("int_n period", last_fall - prev_fall, FRAME_LEN);
				end
				OP_SRST: begin
					io_write(t.addr, t.data);
					@(negedge fclk);
					check_bit("res", res, 1'b1);
					while (res)
						@(negedge fclk);
				end
				default:
					fail_run($sformatf("unknown operation %h in test %0d", t.op, i));
			endcase
			@(negedge fclk);
			check_border("border", border, t.border);
			check_turbo("turbo", turbo, t.turbo);
			check_rompg("rompg", rompg, t.rompg);
			check_bit("beep", beep, t.beep);
			idle_gap();
		end

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/zcore_tests.txt
# op addr data | expected: border turbo rompg beep read
# op: 1 write, 2 read, 3 read not driven, 4 int ack, 5 int pulse, 6 soft reset
1 0FAF AA AA 0 00 0 00
1 00FE 15 AD 0 00 1 00
1 20AF 03 AD 3 00 1 00
1 21AF FD AD 3 1D 1 00
1 20AF 06 AD 2 1D 1 00
2 0FAF 00 AD 2 1D 1 AD
2 20AF 00 AD 2 1D 1 06
2 21AF 00 AD 2 1D 1 FD
3 12FE 00 AD 2 1D 1 00
3 3FAF 00 AD 2 1D 1 00
1 7FFE 08 A8 2 1D 0 00
4 0000 00 A8 2 1D 0 FF
1 24AF 5C A8 2 1D 0 00
2 24AF 00 A8 2 1D 0 5C
5 0000 00 A8 2 1D 0 00
4 0000 00 A8 2 1D 0 5C
6 20AF 81 00 0 00 0 00
2 20AF 00 00 0 00 0 00
2 21AF 00 00 0 00 0 00
2 24AF 00 00 0 00 0 FF

// File: src.f
rtl/z80_pkg.sv
rtl/conf_pkg.sv
rtl/zsignals.sv
rtl/resetter.sv
rtl/zports.sv
rtl/zint.sv
rtl/zcore.sv
verif/zcore_assert.sv
verif/tb_zcore.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_zcore
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
